//--- logic/zipdbg_settings.svh
/*
 * Debug port widths, power-up reset hold and start mode
 * Control-word command bit positions and the control selector bit
 */
`ifndef ZIPDBG_SETTINGS_SVH
`define ZIPDBG_SETTINGS_SVH

// Debug bus byte address and data widths
`define DBG_ADDR_WIDTH 8
`define DBG_DATA_WIDTH 32

// Byte offset bits dropped to form the word address
`define DBG_WORD_LSB 2

// Cycles the CPU is held in reset after power-up
`define RESET_DURATION 10

// 1 halts on break, 0 resets on break
`define START_HALTED 0

// Control word command bits
`define RESET_BIT 6
`define STEP_BIT 8
`define HALT_BIT 10
`define CLEAR_CACHE_BIT 11

// Word address bit picking control word over CPU register
`define CTRL_SEL_BIT 5

`endif

//--- logic/zipdbg_pkg.sv
/*
 * Types shared by the debug front end
 * Debug address and write items, control word union,
 * register-write, core state and status word layouts
 */
`include "zipdbg_settings.svh"

package dbg_pkg;

	// Word address after the byte offset is dropped
	typedef logic [`DBG_ADDR_WIDTH-`DBG_WORD_LSB-1:0] dbg_aw_t;

	// Write data item, strobes on top
	typedef struct packed {
		logic [`DBG_DATA_WIDTH/8-1:0] strb;
		logic [`DBG_DATA_WIDTH-1:0] data;
	} dbg_w_t;

	// Command fields of the control word
	// Clear cache sits right above halt
	typedef struct packed {
		logic [`DBG_DATA_WIDTH-`CLEAR_CACHE_BIT-2:0] rsvd_hi;
		logic clear_cache;
		logic halt;
		logic [`HALT_BIT-`STEP_BIT-2:0] rsvd_mid;
		logic step;
		logic [`STEP_BIT-`RESET_BIT-2:0] rsvd_low;
		logic reset;
		logic [`RESET_BIT-1:0] rsvd_lsb;
	} ctrl_cmd_t;

	// Same write word, register value or commands
	typedef union packed {
		logic [`DBG_DATA_WIDTH-1:0] raw;
		ctrl_cmd_t cmd;
	} dbg_wdata_u;

	// Register write toward the core
	typedef struct packed {
		logic we;
		logic [`CTRL_SEL_BIT-1:0] idx;
		logic [`DBG_DATA_WIDTH-1:0] data;
	} reg_write_t;

	// Debug-side state reported by the core
	typedef struct packed {
		logic stall;
		logic brk;
		logic [2:0] cc;
	} core_state_t;

	// Status word as read back by the debugger
	typedef struct packed {
		logic [14:0] zero_hi;
		logic interrupt_hi;
		logic zero_15;
		logic brk;
		logic [2:0] cc;
		logic halt;
		logic halted;
		logic zero_8;
		logic interrupt;
		logic reset;
		logic [5:0] zero_lo;
	} cpu_status_t;

	// Control word write, single-cycle strobe
	typedef struct packed {
		logic stb;
		dbg_wdata_u data;
		logic [`DBG_DATA_WIDTH/8-1:0] strb;
	} ctrl_write_t;

endpackage

//--- logic/dbg_skid.sv
/*
 * One-entry valid/ready skid buffer, no output register
 */
`timescale 1ns/1ns

module dbg_skid #(
	parameter int DW = 8
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_valid,
	output logic o_ready,
	input  logic [DW-1:0] i_data,
	output logic o_valid,
	input  logic i_ready,
	output logic [DW-1:0] o_data
);

	// Item caught while downstream stalled
	logic r_valid;
	logic [DW-1:0] r_data;

	// Catch on an upstream transfer that is not taken downstream
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Payload only moves while the slot is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Upstream waits while an item is held
	assign o_ready = !r_valid;

	// Held item leaves before new data
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

endmodule

//--- logic/dbg_write_port.sv
/*
 * Debug write channel handling
 * AW/W join, register-write capture toward the core,
 * control-word strobe and B response
 */
`timescale 1ns/1ns
`include "zipdbg_settings.svh"

module dbg_write_port (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_aw_valid,
	output logic o_aw_ready,
	input  dbg_pkg::dbg_aw_t i_aw,
	input  logic i_w_valid,
	output logic o_w_ready,
	input  dbg_pkg::dbg_w_t i_w,
	output logic o_bvalid,
	input  logic i_bready,
	output logic [1:0] o_bresp,
	input  dbg_pkg::core_state_t i_core,
	output dbg_pkg::reg_write_t o_reg_write,
	output dbg_pkg::ctrl_write_t o_ctrl_write
);

	logic ctrl_sel;
	logic accept;
	logic write_stall;
	logic reg_we;
	logic [`CTRL_SEL_BIT-1:0] reg_idx;
	logic [`DBG_DATA_WIDTH-1:0] reg_data;

	//////////////////////////////////////////////////////////////////////
	// Acceptance
	//////////////////////////////////////////////////////////////////////

	// Selector bit set means control word
	assign ctrl_sel = i_aw[`CTRL_SEL_BIT];

	// Core still busy with the last register write
	assign write_stall = reg_we && i_core.stall;

	// Needs both items and a free B slot
	// Only register writes wait on the core
	assign accept = i_aw_valid && i_w_valid
		&& ((i_w.strb == '0) || ctrl_sel || !write_stall)
		&& (!o_bvalid || i_bready);

	// AW and W leave together
	assign o_aw_ready = accept;
	assign o_w_ready = accept;

	//////////////////////////////////////////////////////////////////////
	// Register write toward the core
	//////////////////////////////////////////////////////////////////////

	// Strobe holds while the core stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			reg_we <= 1'b0;
		else if (!write_stall)
			reg_we <= accept && (|i_w.strb) && !ctrl_sel;
	end

	// Index and value frozen under the same stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
		begin
			reg_idx <= i_aw[`CTRL_SEL_BIT-1:0];
			reg_data <= i_w.data;
		end
	end

	assign o_reg_write = '{we: reg_we, idx: reg_idx, data: reg_data};

	// Control word goes out in the acceptance cycle
	always_comb
	begin
		o_ctrl_write.stb = accept && ctrl_sel;
		o_ctrl_write.data.raw = i_w.data;
		o_ctrl_write.strb = i_w.strb;
	end

	//////////////////////////////////////////////////////////////////////
	// B channel
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (accept)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	// Always OKAY
	assign o_bresp = 2'b00;

endmodule

//--- logic/dbg_read_port.sv
/*
 * Debug read channel handling
 * AR acceptance, register index to the core,
 * status or register data on the R channel
 */
`timescale 1ns/1ns
`include "zipdbg_settings.svh"

module dbg_read_port (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_ar_valid,
	output logic o_ar_ready,
	input  dbg_pkg::dbg_aw_t i_ar,
	output logic o_rvalid,
	input  logic i_rready,
	output logic [`DBG_DATA_WIDTH-1:0] o_rdata,
	output logic [1:0] o_rresp,
	output logic [`CTRL_SEL_BIT-1:0] o_dbg_rreg,
	input  logic [`DBG_DATA_WIDTH-1:0] i_dbg_rdata,
	input  dbg_pkg::cpu_status_t i_status
);

	logic ctrl_sel;
	logic accept;
	// Register read waiting on core data
	logic read_pending;

	assign ctrl_sel = i_ar[`CTRL_SEL_BIT];

	// One register read at a time, R slot must be free
	assign accept = i_ar_valid && !read_pending
		&& (!o_rvalid || i_rready);

	assign o_ar_ready = accept;

	// Index goes to the core straight away
	// Core answers on the next edge
	assign o_dbg_rreg = i_ar[`CTRL_SEL_BIT-1:0];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			read_pending <= 1'b0;
		else
			read_pending <= accept && !ctrl_sel;
	end

	//////////////////////////////////////////////////////////////////////
	// R channel
	//////////////////////////////////////////////////////////////////////

	// Status one cycle after accept, register data two cycles after
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (accept && ctrl_sel) || read_pending;
	end

	// Data holds under back-pressure
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
		begin
			if (read_pending)
				o_rdata <= i_dbg_rdata;
			else
				o_rdata <= i_status;
		end
	end

	assign o_rresp = 2'b00;

endmodule

//--- logic/cpu_run_ctrl.sv
/*
 * CPU run control
 * Power-up reset hold, reset/halt/step/clear-cache commands,
 * status word assembly
 */
`timescale 1ns/1ns
`include "zipdbg_settings.svh"

module cpu_run_ctrl (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_cpu_reset,
	input  logic i_interrupt,
	input  dbg_pkg::ctrl_write_t i_ctrl_write,
	input  dbg_pkg::reg_write_t i_reg_write,
	input  dbg_pkg::core_state_t i_core,
	output logic o_cpu_reset,
	output logic o_cpu_halt,
	output logic o_cpu_clear_cache,
	output dbg_pkg::cpu_status_t o_status
);

	localparam int CW = $clog2(`RESET_DURATION + 1);
	localparam logic [CW-1:0] HOLD_INIT = CW'(`RESET_DURATION);
	localparam logic START_HALT = (`START_HALTED != 0);

	logic [CW-1:0] reset_counter;
	logic reset_hold;
	logic cmd_reset;
	logic cmd_halt;
	logic cmd_step;
	logic cmd_clear_cache;
	// Qualified command writes
	logic wr_reset;
	logic wr_run;
	dbg_pkg::ctrl_cmd_t cmd;

	assign cmd = i_ctrl_write.data.cmd;

	// Reset needs strobe 0, the run commands strobe 1
	assign wr_reset = i_ctrl_write.stb && i_ctrl_write.strb[0];
	assign wr_run = i_ctrl_write.stb && i_ctrl_write.strb[1];

	//////////////////////////////////////////////////////////////////////
	// Power-up reset hold
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_counter <= HOLD_INIT;
		else if (reset_counter != '0)
			reset_counter <= reset_counter - 1'b1;
	end

	// High while the counter runs
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_hold <= 1'b1;
		else
			reset_hold <= (reset_counter > CW'(1));
	end

	//////////////////////////////////////////////////////////////////////
	// Command registers
	//////////////////////////////////////////////////////////////////////

	// Break resets the CPU unless it starts halted
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_reset <= 1'b1;
		else if (reset_hold)
			cmd_reset <= 1'b1;
		else if (i_core.brk && !START_HALT)
			cmd_reset <= 1'b1;
		else
			cmd_reset <= wr_reset && cmd.reset;
	end

	// Later checks win over the release above them
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cmd_halt <= START_HALT;
		else if (i_cpu_reset && !i_ctrl_write.stb && !i_reg_write.we)
			cmd_halt <= START_HALT;
		else if (cmd_reset && START_HALT)
			cmd_halt <= START_HALT;
		else
		begin
			// Release only with no register write in flight
			if (!i_reg_write.we && !i_core.stall && wr_run
					&& (!cmd.halt || cmd.step))
				cmd_halt <= 1'b0;

			// Halt-on-break CPUs stop here
			if (i_core.brk && START_HALT)
				cmd_halt <= 1'b1;

			// Explicit halt, ignored with step
			if (wr_run && cmd.halt && !cmd.step)
				cmd_halt <= 1'b1;

			// Register writes need a stopped CPU
			if (i_reg_write.we)
				cmd_halt <= 1'b1;

			// Stop again after a single step
			if (cmd_step)
				cmd_halt <= 1'b1;

			// Clear cache pending or requested
			if (cmd_clear_cache)
				cmd_halt <= 1'b1;
			if (wr_run && cmd.clear_cache)
				cmd_halt <= 1'b1;
		end
	end

	// Cleared once the halted core stops stalling
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_clear_cache <= 1'b0;
		else if (wr_run && cmd.clear_cache && cmd.halt)
			cmd_clear_cache <= 1'b1;
		else if (cmd_halt && !i_core.stall)
			cmd_clear_cache <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_step <= 1'b0;
		else if (wr_run && cmd.step)
			cmd_step <= 1'b1;
		else if (!i_core.stall)
			cmd_step <= 1'b0;
	end

	assign o_cpu_reset = cmd_reset;
	assign o_cpu_halt = cmd_halt;
	assign o_cpu_clear_cache = cmd_clear_cache;

	// Status word, unused bits zero
	always_comb
	begin
		o_status = '0;
		o_status.interrupt_hi = i_interrupt;
		o_status.brk = i_core.brk;
		o_status.cc = i_core.cc;
		o_status.halt = cmd_halt;
		o_status.halted = !i_core.stall;
		o_status.interrupt = i_interrupt;
		o_status.reset = cmd_reset;
	end

endmodule

//--- logic/zipdbg_top.sv
/*
 * Debug front end top level
 * AXI-lite debug slave, skid buffers, write and read ports, run control
 */
`timescale 1ns/1ns
`include "zipdbg_settings.svh"

module zipdbg_top (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// Debug write address
	input  logic S_DBG_AWVALID,
	output logic S_DBG_AWREADY,
	input  logic [`DBG_ADDR_WIDTH-1:0] S_DBG_AWADDR,
	input  logic [2:0] S_DBG_AWPROT,
	// Debug write data
	input  logic S_DBG_WVALID,
	output logic S_DBG_WREADY,
	input  logic [`DBG_DATA_WIDTH-1:0] S_DBG_WDATA,
	input  logic [`DBG_DATA_WIDTH/8-1:0] S_DBG_WSTRB,
	// Debug write response
	output logic S_DBG_BVALID,
	input  logic S_DBG_BREADY,
	output logic [1:0] S_DBG_BRESP,
	// Debug read address
	input  logic S_DBG_ARVALID,
	output logic S_DBG_ARREADY,
	input  logic [`DBG_ADDR_WIDTH-1:0] S_DBG_ARADDR,
	input  logic [2:0] S_DBG_ARPROT,
	// Debug read data
	output logic S_DBG_RVALID,
	input  logic S_DBG_RREADY,
	output logic [`DBG_DATA_WIDTH-1:0] S_DBG_RDATA,
	output logic [1:0] S_DBG_RRESP,
	// CPU side
	input  logic i_interrupt,
	input  logic i_cpu_reset,
	output logic o_cpu_reset,
	output logic o_cpu_halt,
	output logic o_cpu_clear_cache,
	output dbg_pkg::reg_write_t o_reg_write,
	output logic [`CTRL_SEL_BIT-1:0] o_dbg_rreg,
	input  logic [`DBG_DATA_WIDTH-1:0] i_dbg_rdata,
	input  dbg_pkg::core_state_t i_core
);

	localparam int AW_DW = $bits(dbg_pkg::dbg_aw_t);
	localparam int W_DW = $bits(dbg_pkg::dbg_w_t);

	logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
	dbg_pkg::dbg_aw_t aw_item;
	dbg_pkg::dbg_aw_t ar_item;
	dbg_pkg::dbg_w_t w_item;
	dbg_pkg::ctrl_write_t ctrl_write;
	dbg_pkg::cpu_status_t status;

	//////////////////////////////////////////////////////////////////////
	// Channel skid buffers, byte offset dropped
	//////////////////////////////////////////////////////////////////////

	dbg_skid #(.DW(AW_DW)) aw_skid_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_AWVALID), .o_ready(S_DBG_AWREADY),
		.i_data(S_DBG_AWADDR[`DBG_ADDR_WIDTH-1:`DBG_WORD_LSB]),
		.o_valid(aw_valid), .i_ready(aw_ready), .o_data(aw_item)
	);

	dbg_skid #(.DW(W_DW)) w_skid_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_WVALID), .o_ready(S_DBG_WREADY),
		.i_data({S_DBG_WSTRB, S_DBG_WDATA}),
		.o_valid(w_valid), .i_ready(w_ready), .o_data(w_item)
	);

	dbg_skid #(.DW(AW_DW)) ar_skid_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_ARVALID), .o_ready(S_DBG_ARREADY),
		.i_data(S_DBG_ARADDR[`DBG_ADDR_WIDTH-1:`DBG_WORD_LSB]),
		.o_valid(ar_valid), .i_ready(ar_ready), .o_data(ar_item)
	);

	// Write and read ports side by side
	dbg_write_port write_port_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_aw_valid(aw_valid), .o_aw_ready(aw_ready), .i_aw(aw_item),
		.i_w_valid(w_valid), .o_w_ready(w_ready), .i_w(w_item),
		.o_bvalid(S_DBG_BVALID), .i_bready(S_DBG_BREADY), .o_bresp(S_DBG_BRESP),
		.i_core(i_core),
		.o_reg_write(o_reg_write),
		.o_ctrl_write(ctrl_write)
	);

	dbg_read_port read_port_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_ar_valid(ar_valid), .o_ar_ready(ar_ready), .i_ar(ar_item),
		.o_rvalid(S_DBG_RVALID), .i_rready(S_DBG_RREADY),
		.o_rdata(S_DBG_RDATA), .o_rresp(S_DBG_RRESP),
		.o_dbg_rreg(o_dbg_rreg),
		.i_dbg_rdata(i_dbg_rdata),
		.i_status(status)
	);

	// Run control sees both write kinds and the core state
	cpu_run_ctrl run_ctrl_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset),
		.i_interrupt(i_interrupt),
		.i_ctrl_write(ctrl_write),
		.i_reg_write(o_reg_write),
		.i_core(i_core),
		.o_cpu_reset(o_cpu_reset),
		.o_cpu_halt(o_cpu_halt),
		.o_cpu_clear_cache(o_cpu_clear_cache),
		.o_status(status)
	);

endmodule

//--- tb/tb_clock.sv
/*
 * Testbench clock and reset generator
 */
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic o_clk,
	output logic o_rstn
);

	initial
	begin
		o_clk = 1'b0;
		forever
			#(PERIOD / 2) o_clk = ~o_clk;
	end

	// Reset low for a few edges, released just after an edge
	initial
	begin
		o_rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1 o_rstn = 1'b1;
	end

endmodule

//--- tb/core_model.sv
/*
 * Behavioral CPU debug side
 * Register file, halted flag, stall and registered read data
 */
`timescale 1ns/1ns

module core_model #(
	parameter logic [2:0] CC = 3'b101
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_cpu_reset,
	input  logic i_cpu_halt,
	input  logic i_brk,
	input  dbg_pkg::reg_write_t i_reg_write,
	input  logic [4:0] i_dbg_rreg,
	output logic [31:0] o_dbg_rdata,
	output dbg_pkg::core_state_t o_core
);

	logic halted;
	logic [31:0] regs [0:31];

	// Halted trails the halt request by one cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			halted <= 1'b0;
		else
			halted <= i_cpu_halt;
	end

	// Register file only written once stopped
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_reg_write.we && !o_core.stall)
			regs[i_reg_write.idx] <= i_reg_write.data;
		o_dbg_rdata <= regs[i_dbg_rreg];
	end

	assign o_core.stall = i_cpu_reset || !halted;
	assign o_core.brk = i_brk;
	assign o_core.cc = CC;

endmodule

//--- tb/tb_zipdbg.sv
/*
 * Directed testbench for the debug front end
 * AXI-lite bus tasks, LFSR stimulus, pulse monitors and tests
 */
`timescale 1ns/1ns
`include "zipdbg_settings.svh"

module tb_zipdbg;

	localparam int LIMIT = 50;
	localparam logic [2:0] CORE_CC = 3'b101;
	localparam logic [7:0] CTRL_ADDR = 8'h80;

	logic clk, rstn;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [7:0] awaddr, araddr;
	logic [31:0] wdata, rdata, dbg_rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	logic cpu_reset_in, interrupt, brk;
	logic cpu_reset, cpu_halt, clear_cache;
	logic [4:0] dbg_rreg;
	dbg_pkg::reg_write_t reg_write;
	// Write strobe toward the core on its own
	logic reg_we;
	dbg_pkg::core_state_t core;

	int errors;
	int timeouts;
	logic [31:0] lfsr;
	// Pulse and handshake monitors
	int halt_low_cycles, cc_cycles, reset_cycles, b_count, r_count;

	tb_clock #(.PERIOD(20), .RESET_CYCLES(3)) clock_i (.o_clk(clk), .o_rstn(rstn));

	core_model #(.CC(CORE_CC)) core_i (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.i_cpu_reset(cpu_reset), .i_cpu_halt(cpu_halt), .i_brk(brk),
		.i_reg_write(reg_write), .i_dbg_rreg(dbg_rreg),
		.o_dbg_rdata(dbg_rdata), .o_core(core)
	);

	zipdbg_top dut_i (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.S_DBG_AWVALID(awvalid), .S_DBG_AWREADY(awready),
		.S_DBG_AWADDR(awaddr), .S_DBG_AWPROT(3'b000),
		.S_DBG_WVALID(wvalid), .S_DBG_WREADY(wready),
		.S_DBG_WDATA(wdata), .S_DBG_WSTRB(wstrb),
		.S_DBG_BVALID(bvalid), .S_DBG_BREADY(bready), .S_DBG_BRESP(bresp),
		.S_DBG_ARVALID(arvalid), .S_DBG_ARREADY(arready),
		.S_DBG_ARADDR(araddr), .S_DBG_ARPROT(3'b000),
		.S_DBG_RVALID(rvalid), .S_DBG_RREADY(rready),
		.S_DBG_RDATA(rdata), .S_DBG_RRESP(rresp),
		.i_interrupt(interrupt), .i_cpu_reset(cpu_reset_in),
		.o_cpu_reset(cpu_reset), .o_cpu_halt(cpu_halt),
		.o_cpu_clear_cache(clear_cache), .o_reg_write(reg_write),
		.o_dbg_rreg(dbg_rreg), .i_dbg_rdata(dbg_rdata), .i_core(core)
	);

	assign reg_we = reg_write.we;

	always @(posedge clk)
	begin
		if (!cpu_halt)
			halt_low_cycles++;
		if (clear_cache)
			cc_cycles++;
		if (cpu_reset)
			reset_cycles++;
		if (bvalid && bready)
			b_count++;
		if (rvalid && rready)
			r_count++;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Status layout from the debug register map
	function automatic logic [31:0] status_word(input logic rst, input logic halt,
			input logic halted, input logic intr);
		logic [31:0] s;
		s = '0;
		s[6] = rst;
		s[7] = intr;
		s[9] = halted;
		s[10] = halt;
		s[13:11] = CORE_CC;
		s[16] = intr;
		return s;
	endfunction

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timed out at %0t waiting for %s", $time, what);
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		assert (got === exp)
		else
		begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic send_aw_w(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int n;
		n = 0;
		awvalid = 1'b1;
		awaddr = addr;
		wvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		@(negedge clk);
		while (!(awready && wready) && n < LIMIT)
		begin
			n++;
			@(negedge clk);
		end
		if (n >= LIMIT)
			report_timeout("AW/W ready");
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic wait_b();
		int n;
		n = 0;
		@(negedge clk);
		while (!bvalid && n < LIMIT)
		begin
			n++;
			@(negedge clk);
		end
		if (n >= LIMIT)
			report_timeout("write response");
		check_value(bresp, 2'b00, "BRESP");
		@(posedge clk);
		#1;
	endtask

	task automatic send_ar(input logic [7:0] addr);
		int n;
		n = 0;
		arvalid = 1'b1;
		araddr = addr;
		@(negedge clk);
		while (!arready && n < LIMIT)
		begin
			n++;
			@(negedge clk);
		end
		if (n >= LIMIT)
			report_timeout("AR ready");
		@(posedge clk);
		#1;
		arvalid = 1'b0;
	endtask

	task automatic wait_r(output logic [31:0] data);
		int n;
		n = 0;
		@(negedge clk);
		while (!rvalid && n < LIMIT)
		begin
			n++;
			@(negedge clk);
		end
		if (n >= LIMIT)
			report_timeout("read data");
		data = rdata;
		check_value(rresp, 2'b00, "RRESP");
		@(posedge clk);
		#1;
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		send_aw_w(addr, data, strb);
		wait_b();
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		send_ar(addr);
		wait_r(data);
	endtask

	// Bounded wait for a level on a run-control output
	task automatic wait_level(ref logic sig, input logic level, input string what);
		int n;
		n = 0;
		while (sig !== level && n < LIMIT)
		begin
			n++;
			@(posedge clk);
			#1;
		end
		if (n >= LIMIT)
			report_timeout(what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_hold();
		int n;
		logic [31:0] s;
		n = 0;
		while (rstn !== 1'b1 && n < LIMIT)
		begin
			n++;
			@(negedge clk);
		end
		if (n >= LIMIT)
			report_timeout("reset release");
		n = 0;
		@(posedge clk);
		#1;
		while (cpu_reset && n < LIMIT)
		begin
			n++;
			@(posedge clk);
			#1;
		end
		check_value(n, `RESET_DURATION, "reset hold cycles");
		// Restart the hold from the core side and read during it
		cpu_reset_in = 1'b1;
		@(posedge clk);
		#1;
		cpu_reset_in = 1'b0;
		axi_read(CTRL_ADDR, s);
		check_value(s, status_word(1'b1, 1'b0, 1'b0, 1'b0), "status in reset");
		wait_level(cpu_reset, 1'b0, "end of reset hold");
		axi_read(CTRL_ADDR, s);
		check_value(s, status_word(1'b0, 1'b0, 1'b0, 1'b0), "status after reset");
		check_value(cpu_halt, `START_HALTED, "halt after reset");
	endtask

	task automatic test_halt_release();
		logic [31:0] s;
		axi_write(CTRL_ADDR, 32'h1 << `HALT_BIT, 4'b0010);
		check_value(cpu_halt, 1'b1, "halt set");
		// Interrupt shows in both status bits
		interrupt = 1'b1;
		axi_read(CTRL_ADDR, s);
		interrupt = 1'b0;
		check_value(s, status_word(1'b0, 1'b1, 1'b1, 1'b1), "status halted");
		axi_write(CTRL_ADDR, 32'h0, 4'b0010);
		check_value(cpu_halt, 1'b0, "halt released");
	endtask

	task automatic test_reg_access();
		logic [31:0] shadow [0:31];
		logic [4:0] idx [0:5];
		logic [31:0] got;
		for (int i = 0; i < 6; i++)
		begin
			idx[i] = random_bits(5);
			shadow[idx[i]] = random_bits(32);
			axi_write({1'b0, idx[i], 2'b00}, shadow[idx[i]], 4'hf);
		end
		wait_level(reg_we, 1'b0, "register write to land");
		check_value(cpu_halt, 1'b1, "halt after register writes");
		for (int i = 0; i < 6; i++)
		begin
			axi_read({1'b0, idx[i], 2'b00}, got);
			check_value(got, shadow[idx[i]], "register read back");
		end
	endtask

	task automatic test_step_clear_cache();
		halt_low_cycles = 0;
		axi_write(CTRL_ADDR, 32'h1 << `STEP_BIT, 4'b0010);
		wait_level(cpu_halt, 1'b1, "halt after step");
		check_value(halt_low_cycles > 0 && halt_low_cycles < 5, 1'b1, "step run window");
		cc_cycles = 0;
		axi_write(CTRL_ADDR, (32'h1 << `CLEAR_CACHE_BIT) | (32'h1 << `HALT_BIT), 4'b0010);
		wait_level(clear_cache, 1'b0, "clear cache done");
		check_value(cc_cycles > 0, 1'b1, "clear cache raised");
		check_value(cpu_halt, 1'b1, "halt after clear cache");
	endtask

	task automatic test_reset_pulses();
		reset_cycles = 0;
		axi_write(CTRL_ADDR, 32'h1 << `RESET_BIT, 4'b0001);
		wait_level(cpu_reset, 1'b0, "reset pulse end");
		check_value(reset_cycles, 1, "control reset pulse");
		reset_cycles = 0;
		brk = 1'b1;
		@(posedge clk);
		#1;
		brk = 1'b0;
		@(posedge clk);
		#1;
		wait_level(cpu_reset, 1'b0, "break reset end");
		check_value(reset_cycles, 1, "break reset pulse");
	endtask

	task automatic test_backpressure();
		int base;
		int n;
		logic [31:0] held;
		logic [31:0] got;
		// Write response held
		bready = 1'b0;
		base = b_count;
		send_aw_w(CTRL_ADDR, 32'h0, 4'b0000);
		send_aw_w(CTRL_ADDR, 32'h0, 4'b0000);
		repeat (5)
		begin
			@(negedge clk);
			check_value(bvalid, 1'b1, "BVALID held");
			check_value(awready, 1'b0, "AWREADY under back-pressure");
			check_value(b_count, base, "writes completed under back-pressure");
		end
		@(posedge clk);
		#1;
		bready = 1'b1;
		n = 0;
		while (b_count < base + 2 && n < LIMIT)
		begin
			n++;
			@(posedge clk);
			#1;
		end
		if (n >= LIMIT)
			report_timeout("writes after release");
		// Known register value so a lost hold shows as status data
		axi_write({1'b0, 5'd3, 2'b00}, 32'h5a5ac3c3, 4'hf);
		// Read data held
		rready = 1'b0;
		base = r_count;
		send_ar({1'b0, 5'd3, 2'b00});
		send_ar(CTRL_ADDR);
		@(negedge clk);
		held = rdata;
		check_value(held, 32'h5a5ac3c3, "held register read");
		repeat (5)
		begin
			@(negedge clk);
			check_value(rvalid, 1'b1, "RVALID held");
			check_value(rdata, held, "RDATA held");
			check_value(arready, 1'b0, "ARREADY under back-pressure");
			check_value(r_count, base, "reads completed under back-pressure");
		end
		@(posedge clk);
		#1;
		rready = 1'b1;
		wait_r(got);
		check_value(got, 32'h5a5ac3c3, "first read after release");
		wait_r(got);
		check_value(got, status_word(1'b0, 1'b1, 1'b1, 1'b0), "second read after release");
		check_value(r_count, base + 2, "reads after release");
	endtask

	initial
	begin
		#200000;
		$display("Simulation watchdog expired at %0t", $time);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		errors = 0;
		timeouts = 0;
		lfsr = 32'hac672273;
		halt_low_cycles = 0;
		cc_cycles = 0;
		reset_cycles = 0;
		b_count = 0;
		r_count = 0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b1;
		cpu_reset_in = 1'b0;
		interrupt = 1'b0;
		brk = 1'b0;
		test_reset_hold();
		test_halt_release();
		test_reg_access();
		test_step_clear_cache();
		test_reset_pulses();
		test_backpressure();
		$display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- compile.f
+incdir+logic
logic/zipdbg_pkg.sv
logic/dbg_skid.sv
logic/dbg_write_port.sv
logic/dbg_read_port.sv
logic/cpu_run_ctrl.sv
logic/zipdbg_top.sv
tb/tb_clock.sv
tb/core_model.sv
tb/tb_zipdbg.sv

//--- Makefile
TOP := tb_zipdbg

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f compile.f --top-module zipdbg_top
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
